// ==== include/axi_xbar_defs.svh ====
`ifndef AXI_XBAR_DEFS_SVH
`define AXI_XBAR_DEFS_SVH

// AXI field widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 64
`define AXI_ID_WIDTH 4
`define AXI_LEN_WIDTH 8
`define AXI_RESP_WIDTH 2

// Inclusive address window of the external target
`define TARGET0_ADDR_BASE 32'h0000_0000
`define TARGET0_ADDR_LIMIT 32'h0000_FFFF

// Read response codes
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_DECERR 2'b11

`endif

// ==== design/axi_pkg.sv ====
`include "axi_xbar_defs.svh"

package axi_pkg;

	typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
	typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
	typedef logic [`AXI_ID_WIDTH-1:0] id_t;
	// Beats minus one
	typedef logic [`AXI_LEN_WIDTH-1:0] len_t;
	typedef logic [`AXI_RESP_WIDTH-1:0] resp_t;

endpackage

// ==== design/xbar_pkg.sv ====
package xbar_pkg;

	typedef logic target_t;

	localparam target_t TGT_EXT = 1'b0;
	localparam target_t TGT_ERR = 1'b1;

	typedef enum logic [1:0] {REQ_IDLE, REQ_DECODE, REQ_ISSUE} req_state_e;

	typedef enum logic {RT_IDLE, RT_ROUTE} route_state_e;

	typedef enum logic {ERR_IDLE, ERR_BEATS} err_state_e;

endpackage

// ==== design/ar_request_capture.sv ====
`include "axi_xbar_defs.svh"

module ar_request_capture
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  logic    m_arvalid_i,
	input  addr_t   m_araddr_i,
	input  id_t     m_arid_i,
	input  len_t    m_arlen_i,
	output logic    m_arready_o,
	output logic    s_arvalid_o,
	output addr_t   s_araddr_o,
	output id_t     s_arid_o,
	output len_t    s_arlen_o,
	input  logic    s_arready_i,
	output logic    err_arvalid_o,
	output id_t     err_arid_o,
	output len_t    err_arlen_o,
	input  logic    err_arready_i,
	input  logic    route_busy_i,
	output logic    issue_o,
	output target_t issue_target_o
);

	req_state_e state;
	logic       ready_en;
	addr_t      req_addr;
	id_t        req_id;
	len_t       req_len;
	target_t    req_target;
	logic       in_window;
	logic       tgt_arready;

	assign in_window = (req_addr >= `TARGET0_ADDR_BASE) && (req_addr <= `TARGET0_ADDR_LIMIT);

	// Held off while a response burst is still being routed
	assign m_arready_o = ready_en && (state == REQ_IDLE) && !route_busy_i;

	assign s_arvalid_o   = (state == REQ_ISSUE) && (req_target == TGT_EXT);
	assign err_arvalid_o = (state == REQ_ISSUE) && (req_target == TGT_ERR);
	assign tgt_arready   = (req_target == TGT_EXT) ? s_arready_i : err_arready_i;

	assign issue_o        = (state == REQ_ISSUE) && tgt_arready;
	assign issue_target_o = req_target;

	assign s_araddr_o  = req_addr;
	assign s_arid_o    = req_id;
	assign s_arlen_o   = req_len;
	assign err_arid_o  = req_id;
	assign err_arlen_o = req_len;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state      <= REQ_IDLE;
			ready_en   <= 1'b0;
			req_target <= TGT_ERR;
		end else begin
			ready_en <= 1'b1;
			case (state)
				REQ_IDLE: begin
					if (m_arvalid_i && m_arready_o) begin
						state <= REQ_DECODE;
					end
				end
				REQ_DECODE: begin
					req_target <= in_window ? TGT_EXT : TGT_ERR;
					state      <= REQ_ISSUE;
				end
				REQ_ISSUE: begin
					if (tgt_arready) begin
						state <= REQ_IDLE;
					end
				end
				default: state <= REQ_IDLE;
			endcase
		end
	end

	// Stored request
	always_ff @(posedge clk) begin
		if (m_arvalid_i && m_arready_o) begin
			req_addr <= m_araddr_i;
			req_id   <= m_arid_i;
			req_len  <= m_arlen_i;
		end
	end

endmodule

// ==== design/decode_error_target.sv ====
`include "axi_xbar_defs.svh"

module decode_error_target
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input  logic  clk,
	input  logic  rstn,
	input  logic  arvalid_i,
	input  id_t   arid_i,
	input  len_t  arlen_i,
	output logic  arready_o,
	output logic  rvalid_o,
	output data_t rdata_o,
	output resp_t rresp_o,
	output logic  rlast_o,
	output id_t   rid_o,
	input  logic  rready_i
);

	err_state_e state;
	id_t        rd_id;
	len_t       rd_len;
	len_t       beat_cnt;

	assign arready_o = (state == ERR_IDLE);
	assign rvalid_o  = (state == ERR_BEATS);
	assign rdata_o   = '0;
	assign rresp_o   = `AXI_RESP_DECERR;
	assign rlast_o   = (state == ERR_BEATS) && (beat_cnt == rd_len);
	assign rid_o     = rd_id;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state    <= ERR_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				ERR_IDLE: begin
					if (arvalid_i) begin
						beat_cnt <= '0;
						state    <= ERR_BEATS;
					end
				end
				ERR_BEATS: begin
					if (rready_i) begin
						if (rlast_o) begin
							state <= ERR_IDLE;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
				default: state <= ERR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid_i && arready_o) begin
			rd_id  <= arid_i;
			rd_len <= arlen_i;
		end
	end

endmodule

// ==== design/read_response_router.sv ====
`include "axi_xbar_defs.svh"

module read_response_router
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  logic    issue_i,
	input  target_t issue_target_i,
	output logic    route_busy_o,
	input  logic    s_rvalid_i,
	input  data_t   s_rdata_i,
	input  resp_t   s_rresp_i,
	input  logic    s_rlast_i,
	input  id_t     s_rid_i,
	output logic    s_rready_o,
	input  logic    err_rvalid_i,
	input  data_t   err_rdata_i,
	input  resp_t   err_rresp_i,
	input  logic    err_rlast_i,
	input  id_t     err_rid_i,
	output logic    err_rready_o,
	output logic    m_rvalid_o,
	output data_t   m_rdata_o,
	output resp_t   m_rresp_o,
	output logic    m_rlast_o,
	output id_t     m_rid_o,
	input  logic    m_rready_i
);

	route_state_e state;
	target_t      sel;

	assign route_busy_o = issue_i || (state == RT_ROUTE);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= RT_IDLE;
		end else begin
			case (state)
				RT_IDLE: begin
					if (issue_i) begin
						state <= RT_ROUTE;
					end
				end
				RT_ROUTE: begin
					if (m_rvalid_o && m_rready_i && m_rlast_o) begin
						state <= RT_IDLE;
					end
				end
				default: state <= RT_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_i) begin
			sel <= issue_target_i;
		end
	end

	always_comb begin
		m_rvalid_o   = 1'b0;
		m_rdata_o    = '0;
		m_rresp_o    = `AXI_RESP_OKAY;
		m_rlast_o    = 1'b0;
		m_rid_o      = '0;
		s_rready_o   = 1'b0;
		err_rready_o = 1'b0;
		if (state == RT_ROUTE) begin
			if (sel == TGT_EXT) begin
				m_rvalid_o = s_rvalid_i;
				m_rdata_o  = s_rdata_i;
				m_rresp_o  = s_rresp_i;
				m_rlast_o  = s_rlast_i;
				m_rid_o    = s_rid_i;
				s_rready_o = m_rready_i;
			end else begin
				m_rvalid_o   = err_rvalid_i;
				m_rdata_o    = err_rdata_i;
				m_rresp_o    = err_rresp_i;
				m_rlast_o    = err_rlast_i;
				m_rid_o      = err_rid_i;
				err_rready_o = m_rready_i;
			end
		end
	end

endmodule

// ==== design/axi_read_interconnect.sv ====
module axi_read_interconnect
	import axi_pkg::*;
	import xbar_pkg::*;
(
	input  logic  clk,
	input  logic  rstn,
	input  logic  m_arvalid_i,
	input  addr_t m_araddr_i,
	input  id_t   m_arid_i,
	input  len_t  m_arlen_i,
	output logic  m_arready_o,
	output logic  m_rvalid_o,
	output data_t m_rdata_o,
	output resp_t m_rresp_o,
	output logic  m_rlast_o,
	output id_t   m_rid_o,
	input  logic  m_rready_i,
	output logic  s_arvalid_o,
	output addr_t s_araddr_o,
	output id_t   s_arid_o,
	output len_t  s_arlen_o,
	input  logic  s_arready_i,
	input  logic  s_rvalid_i,
	input  data_t s_rdata_i,
	input  resp_t s_rresp_i,
	input  logic  s_rlast_i,
	input  id_t   s_rid_i,
	output logic  s_rready_o
);

	logic    err_arvalid;
	id_t     err_arid;
	len_t    err_arlen;
	logic    err_arready;
	logic    issue;
	target_t issue_target;
	logic    route_busy;
	logic    err_rvalid;
	data_t   err_rdata;
	resp_t   err_rresp;
	logic    err_rlast;
	id_t     err_rid;
	logic    err_rready;

	ar_request_capture u_capture (
		.clk            (clk),
		.rstn           (rstn),
		.m_arvalid_i    (m_arvalid_i),
		.m_araddr_i     (m_araddr_i),
		.m_arid_i       (m_arid_i),
		.m_arlen_i      (m_arlen_i),
		.m_arready_o    (m_arready_o),
		.s_arvalid_o    (s_arvalid_o),
		.s_araddr_o     (s_araddr_o),
		.s_arid_o       (s_arid_o),
		.s_arlen_o      (s_arlen_o),
		.s_arready_i    (s_arready_i),
		.err_arvalid_o  (err_arvalid),
		.err_arid_o     (err_arid),
		.err_arlen_o    (err_arlen),
		.err_arready_i  (err_arready),
		.route_busy_i   (route_busy),
		.issue_o        (issue),
		.issue_target_o (issue_target)
	);

	read_response_router u_router (
		.clk            (clk),
		.rstn           (rstn),
		.issue_i        (issue),
		.issue_target_i (issue_target),
		.route_busy_o   (route_busy),
		.s_rvalid_i     (s_rvalid_i),
		.s_rdata_i      (s_rdata_i),
		.s_rresp_i      (s_rresp_i),
		.s_rlast_i      (s_rlast_i),
		.s_rid_i        (s_rid_i),
		.s_rready_o     (s_rready_o),
		.err_rvalid_i   (err_rvalid),
		.err_rdata_i    (err_rdata),
		.err_rresp_i    (err_rresp),
		.err_rlast_i    (err_rlast),
		.err_rid_i      (err_rid),
		.err_rready_o   (err_rready),
		.m_rvalid_o     (m_rvalid_o),
		.m_rdata_o      (m_rdata_o),
		.m_rresp_o      (m_rresp_o),
		.m_rlast_o      (m_rlast_o),
		.m_rid_o        (m_rid_o),
		.m_rready_i     (m_rready_i)
	);

	decode_error_target u_err (
		.clk       (clk),
		.rstn      (rstn),
		.arvalid_i (err_arvalid),
		.arid_i    (err_arid),
		.arlen_i   (err_arlen),
		.arready_o (err_arready),
		.rvalid_o  (err_rvalid),
		.rdata_o   (err_rdata),
		.rresp_o   (err_rresp),
		.rlast_o   (err_rlast),
		.rid_o     (err_rid),
		.rready_i  (err_rready)
	);

endmodule

// ==== verif/tb_target_model.sv ====
`include "axi_xbar_defs.svh"

module tb_target_model
	import axi_pkg::*;
(
	input  logic  clk,
	input  logic  rstn,
	input  logic  arvalid_i,
	input  addr_t araddr_i,
	input  id_t   arid_i,
	input  len_t  arlen_i,
	output logic  arready_o,
	output logic  rvalid_o,
	output data_t rdata_o,
	output resp_t rresp_o,
	output logic  rlast_o,
	output id_t   rid_o,
	input  logic  rready_i
);

	addr_t rd_addr;
	id_t   rd_id;
	len_t  rd_len;
	int    accept_delay;

	initial begin
		arready_o = 1'b0;
		rvalid_o  = 1'b0;
		rdata_o   = '0;
		rresp_o   = `AXI_RESP_OKAY;
		rlast_o   = 1'b0;
		rid_o     = '0;
		forever begin
			@(posedge clk);
			if (rstn && arvalid_i) begin
				// Zero to three cycles before the address is taken
				accept_delay = $urandom % 4;
				repeat (accept_delay) @(posedge clk);
				arready_o <= 1'b1;
				@(posedge clk);
				arready_o <= 1'b0;
				rd_addr = araddr_i;
				rd_id   = arid_i;
				rd_len  = arlen_i;
				for (int k = 0; k <= int'(rd_len); k++) begin
					rvalid_o <= 1'b1;
					rdata_o  <= data_t'(rd_addr) + data_t'(k);
					rresp_o  <= `AXI_RESP_OKAY;
					rlast_o  <= (k == int'(rd_len));
					rid_o    <= rd_id;
					@(posedge clk);
					while (!rready_i) @(posedge clk);
				end
				rvalid_o <= 1'b0;
				rlast_o  <= 1'b0;
			end
		end
	end

endmodule

// ==== verif/tb_axi_read_interconnect.sv ====
`include "axi_xbar_defs.svh"

module tb_axi_read_interconnect
	import axi_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000;

	logic  clk;
	logic  rstn;
	logic  m_arvalid;
	addr_t m_araddr;
	id_t   m_arid;
	len_t  m_arlen;
	logic  m_arready;
	logic  m_rvalid;
	data_t m_rdata;
	resp_t m_rresp;
	logic  m_rlast;
	id_t   m_rid;
	logic  m_rready;
	logic  s_arvalid;
	addr_t s_araddr;
	id_t   s_arid;
	len_t  s_arlen;
	logic  s_arready;
	logic  s_rvalid;
	data_t s_rdata;
	resp_t s_rresp;
	logic  s_rlast;
	id_t   s_rid;
	logic  s_rready;

	int cycle_cnt;
	int value_errors;
	int other_errors;
	int last_cycle;
	int accept_cycle;
	bit ext_ar_seen;
	bit random_ready;

	data_t rx_data[$];
	resp_t rx_resp[$];
	id_t   rx_id[$];
	bit    rx_last[$];

	axi_read_interconnect u_dut (
		.clk         (clk),
		.rstn        (rstn),
		.m_arvalid_i (m_arvalid),
		.m_araddr_i  (m_araddr),
		.m_arid_i    (m_arid),
		.m_arlen_i   (m_arlen),
		.m_arready_o (m_arready),
		.m_rvalid_o  (m_rvalid),
		.m_rdata_o   (m_rdata),
		.m_rresp_o   (m_rresp),
		.m_rlast_o   (m_rlast),
		.m_rid_o     (m_rid),
		.m_rready_i  (m_rready),
		.s_arvalid_o (s_arvalid),
		.s_araddr_o  (s_araddr),
		.s_arid_o    (s_arid),
		.s_arlen_o   (s_arlen),
		.s_arready_i (s_arready),
		.s_rvalid_i  (s_rvalid),
		.s_rdata_i   (s_rdata),
		.s_rresp_i   (s_rresp),
		.s_rlast_i   (s_rlast),
		.s_rid_i     (s_rid),
		.s_rready_o  (s_rready)
	);

	tb_target_model u_target (
		.clk       (clk),
		.rstn      (rstn),
		.arvalid_i (s_arvalid),
		.araddr_i  (s_araddr),
		.arid_i    (s_arid),
		.arlen_i   (s_arlen),
		.arready_o (s_arready),
		.rvalid_o  (s_rvalid),
		.rdata_o   (s_rdata),
		.rresp_o   (s_rresp),
		.rlast_o   (s_rlast),
		.rid_o     (s_rid),
		.rready_i  (s_rready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (s_arvalid) begin
			ext_ar_seen <= 1'b1;
		end
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic check_data(string name, data_t got, data_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_resp(string name, resp_t got, resp_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_id(string name, id_t got, id_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_last(string name, bit got, bit exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(string what);
		other_errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic check_idle_outputs();
		check_flag("m_arready_o", m_arready, 1'b0);
		check_flag("m_rvalid_o", m_rvalid, 1'b0);
		check_flag("s_arvalid_o", s_arvalid, 1'b0);
		check_flag("s_rready_o", s_rready, 1'b0);
	endtask

	task automatic drive_ar(addr_t addr, id_t id, len_t len);
		m_arvalid <= 1'b1;
		m_araddr  <= addr;
		m_arid    <= id;
		m_arlen   <= len;
		@(posedge clk);
		while (!m_arready) @(posedge clk);
		accept_cycle = cycle_cnt;
		m_arvalid <= 1'b0;
	endtask

	// Gathers beats until the last-beat handshake
	task automatic collect_burst();
		bit done;
		done = 1'b0;
		rx_data.delete();
		rx_resp.delete();
		rx_id.delete();
		rx_last.delete();
		while (!done) begin
			@(posedge clk);
			if (m_rvalid && m_rready) begin
				rx_data.push_back(m_rdata);
				rx_resp.push_back(m_rresp);
				rx_id.push_back(m_rid);
				rx_last.push_back(m_rlast);
				if (m_rlast) begin
					done = 1'b1;
					last_cycle = cycle_cnt;
				end
			end
			if (random_ready) begin
				m_rready <= 1'($urandom % 2);
			end
		end
		m_rready <= 1'b1;
	endtask

	task automatic check_burst(addr_t addr, id_t id, len_t len);
		bit    in_win;
		data_t exp_data;
		resp_t exp_resp;
		in_win = (addr >= `TARGET0_ADDR_BASE) && (addr <= `TARGET0_ADDR_LIMIT);
		exp_resp = in_win ? `AXI_RESP_OKAY : `AXI_RESP_DECERR;
		if (rx_data.size() != int'(len) + 1) begin
			report_failure($sformatf("read at %h gave %0d beats instead of %0d",
				addr, rx_data.size(), int'(len) + 1));
		end
		for (int k = 0; k < rx_data.size(); k++) begin
			exp_data = in_win ? data_t'(addr) + data_t'(k) : data_t'(0);
			check_data($sformatf("rdata[%0d]", k), rx_data[k], exp_data);
			check_resp($sformatf("rresp[%0d]", k), rx_resp[k], exp_resp);
			check_id($sformatf("rid[%0d]", k), rx_id[k], id);
			check_last($sformatf("rlast[%0d]", k), rx_last[k], k == int'(len));
		end
	endtask

	task automatic read_test(addr_t addr, id_t id, len_t len);
		drive_ar(addr, id, len);
		collect_burst();
		check_burst(addr, id, len);
	endtask

	task automatic test_reset_outputs();
		// Outputs are defined from the first reset edge on
		@(posedge clk);
		repeat (15) begin
			@(posedge clk);
			check_idle_outputs();
		end
		rstn <= 1'b1;
		@(posedge clk);
		check_idle_outputs();
	endtask

	task automatic test_decode_error();
		ext_ar_seen = 1'b0;
		read_test(32'h0001_0000, 4'h5, 8'd3);
		if (ext_ar_seen) begin
			report_failure("out-of-window read raised s_arvalid_o");
		end
	endtask

	task automatic test_ready_toggle();
		random_ready = 1'b1;
		read_test(32'h0000_2000, 4'h3, 8'd7);
		random_ready = 1'b0;
	endtask

	// Second AR stays valid while the first burst is routed
	task automatic test_back_to_back(addr_t addr_a, id_t id_a, len_t len_a,
		addr_t addr_b, id_t id_b, len_t len_b);
		drive_ar(addr_a, id_a, len_a);
		fork
			collect_burst();
			drive_ar(addr_b, id_b, len_b);
		join
		if (accept_cycle <= last_cycle) begin
			report_failure("second AR was accepted before the first burst's last beat");
		end
		check_burst(addr_a, id_a, len_a);
		collect_burst();
		check_burst(addr_b, id_b, len_b);
	endtask

	initial begin
		void'($urandom(32'h1272_b85b));
		cycle_cnt    = 0;
		value_errors = 0;
		other_errors = 0;
		last_cycle   = 0;
		accept_cycle = 0;
		ext_ar_seen  = 1'b0;
		random_ready = 1'b0;
		rstn         = 1'b0;
		m_arvalid    = 1'b0;
		m_araddr     = '0;
		m_arid       = '0;
		m_arlen      = '0;
		m_rready     = 1'b1;

		test_reset_outputs();
		read_test(32'h0000_1234, 4'h1, 8'd0);
		read_test(32'h0000_8000, 4'h2, 8'd15);
		test_decode_error();
		test_ready_toggle();
		test_back_to_back(32'h0000_0400, 4'h6, 8'd3, 32'h0002_0000, 4'h7, 8'd1);
		test_back_to_back(32'h1000_0000, 4'h8, 8'd2, 32'h0000_FFF0, 4'h9, 8'd4);

		$display("Checks done with %0d value errors and %0d other errors",
			value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
design/axi_pkg.sv
design/xbar_pkg.sv
design/ar_request_capture.sv
design/decode_error_target.sv
design/read_response_router.sv
design/axi_read_interconnect.sv
verif/tb_target_model.sv
verif/tb_axi_read_interconnect.sv

// ==== Bender.yml ====
package:
  name: axi_read_interconnect

export_include_dirs:
  - include

sources:
  - files:
      - design/axi_pkg.sv
      - design/xbar_pkg.sv
      - design/ar_request_capture.sv
      - design/decode_error_target.sv
      - design/read_response_router.sv
      - design/axi_read_interconnect.sv
  - target: test
    files:
      - verif/tb_target_model.sv
      - verif/tb_axi_read_interconnect.sv
